/* src/fetch_pkg.sv */
package fetch_pkg;

    // address and instruction widths
    localparam int ADDR_W = 32;
    localparam int INSTR_W = 32;

    // block geometry: four words of four bytes
    localparam int BYTE_OFFSET_W = 2;
    localparam int WORD_SEL_W = 2;
    localparam int BLOCK_OFFSET_W = BYTE_OFFSET_W + WORD_SEL_W;
    localparam int BLOCK_ADDR_W = ADDR_W - BLOCK_OFFSET_W;
    localparam int BLOCK_W = INSTR_W << WORD_SEL_W;

    // direct-mapped icache
    localparam int ICACHE_SETS = 16;
    localparam int ICACHE_INDEX_W = $clog2(ICACHE_SETS);
    localparam int ICACHE_TAG_W = BLOCK_ADDR_W - ICACHE_INDEX_W;

    // instruction queue
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [BLOCK_W-1:0] block_data_t;
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;
    typedef logic [ICACHE_INDEX_W-1:0] cache_index_t;
    typedef logic [ICACHE_TAG_W-1:0] cache_tag_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [6:0] opcode_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // one extra bit so a full queue is representable
    typedef logic [FIFO_PTR_W:0] fifo_count_t;

    localparam addr_t RESET_PC = '0;
    localparam addr_t INSTR_BYTES = 4;

    // rv32 major opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL = 7'b1101111;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_REQUEST,
        REFILL_WAIT_RESP
    } refill_state_t;

endpackage

/* src/fetch_entry_if.sv */
interface fetch_entry_if;
    import fetch_pkg::*;

    // fetched word and where it came from
    logic valid;
    instr_t instr;
    addr_t pc;
    // predecode results
    logic is_cond_br;
    logic br_pred;
    // predicted next pc, also steers fetch
    addr_t br_target;

    modport producer (
        output valid,
        output instr,
        output pc
    );

    modport decoder (
        input  instr,
        input  pc,
        output is_cond_br,
        output br_pred,
        output br_target
    );

    modport consumer (
        input valid,
        input instr,
        input pc,
        input is_cond_br,
        input br_pred,
        input br_target
    );

endinterface

/* src/fetch_pc_icache.sv */
module fetch_pc_icache (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   backend_stall,
    input  logic                   recovery_valid,
    input  fetch_pkg::addr_t       recovery_pc,
    input  fetch_pkg::addr_t       next_pc,
    input  logic                   enq_ready,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    input  fetch_pkg::block_data_t mem_resp_data,
    output logic                   mem_req_valid,
    output fetch_pkg::block_addr_t mem_req_block_addr,
    fetch_entry_if.producer        entry
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_d;
    cache_index_t pc_index;
    cache_tag_t pc_tag;
    word_sel_t pc_word;

    // cache arrays, only the valid bits are cleared
    cache_tag_t tag_mem [ICACHE_SETS];
    block_data_t data_mem [ICACHE_SETS];
    logic [ICACHE_SETS-1:0] valid_bits;

    block_data_t hit_block;
    logic hit;

    refill_state_t refill_state;
    block_addr_t refill_block;
    cache_index_t refill_index;
    cache_tag_t refill_tag;
    logic refill_done;

    // split the registered pc
    assign pc_word = pc_q[BYTE_OFFSET_W +: WORD_SEL_W];
    assign pc_index = pc_q[BLOCK_OFFSET_W +: ICACHE_INDEX_W];
    assign pc_tag = pc_q[ADDR_W-1 -: ICACHE_TAG_W];

    // combinational lookup
    assign hit_block = data_mem[pc_index];
    assign hit = valid_bits[pc_index] && (tag_mem[pc_index] == pc_tag);

    assign entry.instr = hit_block[pc_word * INSTR_W +: INSTR_W];
    assign entry.pc = pc_q;
    // a hit only counts when the queue takes it and nothing holds fetch
    assign entry.valid = hit && enq_ready && !backend_stall && !recovery_valid;

    // pc mux, recovery first
    always_comb begin
        if (recovery_valid) begin
            pc_d = recovery_pc;
        end else if (entry.valid) begin
            pc_d = next_pc;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // refill fsm
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refill_state <= REFILL_IDLE;
        end else begin
            case (refill_state)
                REFILL_IDLE: begin
                    if (!hit) begin
                        refill_state <= REFILL_REQUEST;
                    end
                end
                REFILL_REQUEST: begin
                    if (mem_req_ready) begin
                        refill_state <= REFILL_WAIT_RESP;
                    end
                end
                REFILL_WAIT_RESP: begin
                    if (mem_resp_valid) begin
                        refill_state <= REFILL_IDLE;
                    end
                end
                default: begin
                    refill_state <= REFILL_IDLE;
                end
            endcase
        end
    end

    // missing block captured at the miss, survives a redirect
    always_ff @(posedge clk) begin
        if (refill_state == REFILL_IDLE && !hit) begin
            refill_block <= pc_q[ADDR_W-1:BLOCK_OFFSET_W];
        end
    end

    assign refill_index = refill_block[ICACHE_INDEX_W-1:0];
    assign refill_tag = refill_block[BLOCK_ADDR_W-1 -: ICACHE_TAG_W];
    assign refill_done = (refill_state == REFILL_WAIT_RESP) && mem_resp_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
        end else if (refill_done) begin
            valid_bits[refill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_mem[refill_index] <= refill_tag;
            data_mem[refill_index] <= mem_resp_data;
        end
    end

    assign mem_req_valid = (refill_state == REFILL_REQUEST);
    assign mem_req_block_addr = refill_block;

    // request held until the controller takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_block_addr));

    // controller answers only an accepted request
    a_resp_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp_valid |-> refill_state == REFILL_WAIT_RESP);

endmodule

/* src/predecode_npc.sv */
module predecode_npc (
    fetch_entry_if.decoder entry
);
    import fetch_pkg::*;

    opcode_t opcode;
    logic is_jal;
    addr_t imm_b;
    addr_t imm_j;
    addr_t seq_pc;

    assign opcode = entry.instr[6:0];
    assign is_jal = (opcode == OPC_JAL);
    assign entry.is_cond_br = (opcode == OPC_BRANCH);

    // b-type immediate, bit 0 implied zero
    assign imm_b = {
        {20{entry.instr[31]}},
        entry.instr[7],
        entry.instr[30:25],
        entry.instr[11:8],
        1'b0
    };

    // j-type immediate
    assign imm_j = {
        {12{entry.instr[31]}},
        entry.instr[19:12],
        entry.instr[20],
        entry.instr[30:21],
        1'b0
    };

    // backward branch predicted taken
    assign entry.br_pred = entry.is_cond_br && imm_b[ADDR_W-1];

    assign seq_pc = entry.pc + INSTR_BYTES;

    // target mux
    always_comb begin
        if (is_jal) begin
            entry.br_target = entry.pc + imm_j;
        end else if (entry.br_pred) begin
            entry.br_target = entry.pc + imm_b;
        end else begin
            // not taken or not a control transfer
            entry.br_target = seq_pc;
        end
    end

endmodule

/* src/instr_fifo.sv */
module instr_fifo (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              recovery_valid,
    input  logic              dispatch_ready,
    output logic              enq_ready,
    output logic              dispatch_valid,
    output fetch_pkg::instr_t dispatch_instr,
    output fetch_pkg::addr_t  dispatch_pc,
    output logic              dispatch_is_cond_br,
    output logic              dispatch_br_pred,
    output fetch_pkg::addr_t  dispatch_br_target,
    fetch_entry_if.consumer   entry
);
    import fetch_pkg::*;

    // entry storage, one array per field
    instr_t instr_mem [FIFO_DEPTH];
    addr_t pc_mem [FIFO_DEPTH];
    addr_t target_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] cond_mem;
    logic [FIFO_DEPTH-1:0] pred_mem;

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_count_t count;
    logic full;
    logic enq;
    logic deq;

    assign full = (count == fifo_count_t'(FIFO_DEPTH));
    assign enq_ready = !full;
    assign enq = entry.valid && !full;
    assign dispatch_valid = (count != '0);
    assign deq = dispatch_valid && dispatch_ready;

    always_ff @(posedge clk) begin
        if (enq) begin
            instr_mem[wr_ptr] <= entry.instr;
            pc_mem[wr_ptr] <= entry.pc;
            target_mem[wr_ptr] <= entry.br_target;
            cond_mem[wr_ptr] <= entry.is_cond_br;
            pred_mem[wr_ptr] <= entry.br_pred;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (recovery_valid) begin
            // redirect drops everything queued
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(enq);
            rd_ptr <= rd_ptr + fifo_ptr_t'(deq);
            count <= count + fifo_count_t'(enq) - fifo_count_t'(deq);
        end
    end

    // head of queue
    assign dispatch_instr = instr_mem[rd_ptr];
    assign dispatch_pc = pc_mem[rd_ptr];
    assign dispatch_br_target = target_mem[rd_ptr];
    assign dispatch_is_cond_br = cond_mem[rd_ptr];
    assign dispatch_br_pred = pred_mem[rd_ptr];

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= fifo_count_t'(FIFO_DEPTH));

    // fetch must already see the full queue and hold off
    a_no_enq_full: assert property (@(posedge clk) disable iff (!arst_n)
        entry.valid |-> !full);

endmodule

/* src/ifu.sv */
module ifu (
    input  logic                   clk,
    input  logic                   arst_n,
    // backend control
    input  logic                   backend_stall,
    input  logic                   recovery_valid,
    input  fetch_pkg::addr_t       recovery_pc,
    // memory controller request
    output logic                   mem_req_valid,
    output fetch_pkg::block_addr_t mem_req_block_addr,
    input  logic                   mem_req_ready,
    // memory controller response
    input  logic                   mem_resp_valid,
    input  fetch_pkg::block_data_t mem_resp_data,
    // dispatch side
    input  logic                   dispatch_ready,
    output logic                   dispatch_valid,
    output fetch_pkg::instr_t      dispatch_instr,
    output fetch_pkg::addr_t       dispatch_pc,
    output logic                   dispatch_is_cond_br,
    output logic                   dispatch_br_pred,
    output fetch_pkg::addr_t       dispatch_br_target
);

    // fetched entry shared by cache, predecoder and queue
    fetch_entry_if entry_bus ();

    // queue has room
    logic enq_ready;

    fetch_pc_icache u_fetch_pc_icache (
        .clk                (clk),
        .arst_n             (arst_n),
        .backend_stall      (backend_stall),
        .recovery_valid     (recovery_valid),
        .recovery_pc        (recovery_pc),
        // predicted target is the next fetch pc
        .next_pc            (entry_bus.br_target),
        .enq_ready          (enq_ready),
        .mem_req_ready      (mem_req_ready),
        .mem_resp_valid     (mem_resp_valid),
        .mem_resp_data      (mem_resp_data),
        .mem_req_valid      (mem_req_valid),
        .mem_req_block_addr (mem_req_block_addr),
        .entry              (entry_bus.producer)
    );

    predecode_npc u_predecode_npc (
        .entry (entry_bus.decoder)
    );

    instr_fifo u_instr_fifo (
        .clk                 (clk),
        .arst_n              (arst_n),
        .recovery_valid      (recovery_valid),
        .dispatch_ready      (dispatch_ready),
        .enq_ready           (enq_ready),
        .dispatch_valid      (dispatch_valid),
        .dispatch_instr      (dispatch_instr),
        .dispatch_pc         (dispatch_pc),
        .dispatch_is_cond_br (dispatch_is_cond_br),
        .dispatch_br_pred    (dispatch_br_pred),
        .dispatch_br_target  (dispatch_br_target),
        .entry               (entry_bus.consumer)
    );

endmodule

/* sim/tb_mem_model.sv */
module tb_mem_model (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  fetch_pkg::block_addr_t req_block_addr,
    output logic                   req_ready,
    output logic                   resp_valid,
    output fetch_pkg::block_data_t resp_data,
    input  fetch_pkg::addr_t       probe_addr,
    output fetch_pkg::instr_t      probe_word
);
    import fetch_pkg::*;

    int seed = 67490;
    int rand_val = 0;
    // cycles left until the response
    int delay = 0;
    logic busy = 1'b0;
    block_addr_t pending;

    // program image, every word a function of its byte address
    function automatic instr_t word_at(input addr_t a);
        case (a)
            // beq x0, x0, -16
            32'h40: return 32'hfe0008e3;
            // beq x0, x0, +16
            32'h80: return 32'h00000863;
            // jal x0, 0x20
            32'h100: return 32'hf21ff06f;
            // addi x1, x0, a[13:2]
            default: return {a[13:2], 5'd0, 3'd0, 5'd1, 7'h13};
        endcase
    endfunction

    function automatic block_data_t block_at(input block_addr_t b);
        block_data_t d;
        for (int w = 0; w < 4; w++) begin
            d[w*32 +: 32] = word_at({b, 2'(w), 2'b00});
        end
        return d;
    endfunction

    // lets the testbench look up the expected word
    assign probe_word = word_at(probe_addr);

    initial begin
        req_ready = 1'b0;
        resp_valid = 1'b0;
        resp_data = '0;
    end

    always @(posedge clk) begin
        // request taken on this edge
        if (arst_n && req_valid && req_ready) begin
            pending = req_block_addr;
            busy = 1'b1;
            rand_val = $random(seed);
            delay = 1 + (rand_val & 32'hffff) % 6;
        end
        #5;
        resp_valid = 1'b0;
        if (busy) begin
            delay = delay - 1;
            if (delay == 0) begin
                // one-cycle pulse with the whole block
                resp_valid = 1'b1;
                resp_data = block_at(pending);
                busy = 1'b0;
            end
        end
        rand_val = $random(seed);
        req_ready = !busy && rand_val[0];
    end

endmodule

/* sim/tb_ifu.sv */
module tb_ifu;
    import fetch_pkg::*;

    logic clk;
    logic arst_n;
    logic backend_stall;
    logic recovery_valid;
    addr_t recovery_pc;
    logic mem_req_valid;
    block_addr_t mem_req_block_addr;
    logic mem_req_ready;
    logic mem_resp_valid;
    block_data_t mem_resp_data;
    logic dispatch_ready;
    logic dispatch_valid;
    instr_t dispatch_instr;
    addr_t dispatch_pc;
    logic dispatch_is_cond_br;
    logic dispatch_br_pred;
    addr_t dispatch_br_target;
    // memory word at dispatch_pc
    instr_t mem_word;

    // checker state
    addr_t expect_pc;
    addr_t watch_pc;
    int watch_hits;
    int deq_count;
    int stall_deqs;
    logic hold_pending;
    logic [97:0] dispatch_fields;
    logic [97:0] held_fields;
    int errors;
    int test_base;
    int tests_passed;
    int tests_failed;
    logic timed_out;
    int seed;
    int ready_rand;
    logic ready_low;

    ifu uut (
        .clk                 (clk),
        .arst_n              (arst_n),
        .backend_stall       (backend_stall),
        .recovery_valid      (recovery_valid),
        .recovery_pc         (recovery_pc),
        .mem_req_valid       (mem_req_valid),
        .mem_req_block_addr  (mem_req_block_addr),
        .mem_req_ready       (mem_req_ready),
        .mem_resp_valid      (mem_resp_valid),
        .mem_resp_data       (mem_resp_data),
        .dispatch_ready      (dispatch_ready),
        .dispatch_valid      (dispatch_valid),
        .dispatch_instr      (dispatch_instr),
        .dispatch_pc         (dispatch_pc),
        .dispatch_is_cond_br (dispatch_is_cond_br),
        .dispatch_br_pred    (dispatch_br_pred),
        .dispatch_br_target  (dispatch_br_target)
    );

    tb_mem_model mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (mem_req_valid),
        .req_block_addr (mem_req_block_addr),
        .req_ready      (mem_req_ready),
        .resp_valid     (mem_resp_valid),
        .resp_data      (mem_resp_data),
        .probe_addr     (dispatch_pc),
        .probe_word     (mem_word)
    );

    always #20 clk = ~clk;

    assign dispatch_fields = {dispatch_instr, dispatch_pc, dispatch_br_target,
                              dispatch_is_cond_br, dispatch_br_pred};

    // reference prediction from the rv32 encodings
    function automatic logic ref_cond(input instr_t w);
        return w[6:0] == 7'h63;
    endfunction

    // sign of the b offset is bit 31, backward means taken
    function automatic logic ref_pred(input instr_t w);
        return ref_cond(w) && w[31];
    endfunction

    function automatic addr_t ref_target(input addr_t pc, input instr_t w);
        addr_t off_b;
        addr_t off_j;
        off_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        off_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (w[6:0] == 7'h6f) begin
            return pc + off_j;
        end else if (ref_pred(w)) begin
            return pc + off_b;
        end
        return pc + 32'd4;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    // sampled at the edge, inputs move 5 later
    always @(posedge clk) begin
        if (!arst_n) begin
            assert (!dispatch_valid && !mem_req_valid)
                else report_mismatch("dispatch_valid or mem_req_valid high in reset");
        end else begin
            // only blocks of the program image get requested
            if (mem_req_valid) begin
                assert (mem_req_block_addr <= 28'h10)
                    else report_mismatch($sformatf("request for block %h", mem_req_block_addr));
            end
            if (hold_pending) begin
                assert (dispatch_valid && dispatch_fields == held_fields)
                    else report_mismatch("dispatch entry changed while ready was low");
            end
            if (dispatch_valid) begin
                assert (dispatch_instr == mem_word)
                    else report_mismatch($sformatf("instr %h at pc %h, expected %h",
                        dispatch_instr, dispatch_pc, mem_word));
                assert (dispatch_is_cond_br == ref_cond(mem_word)
                        && dispatch_br_pred == ref_pred(mem_word))
                    else report_mismatch($sformatf("branch flags wrong at pc %h", dispatch_pc));
                assert (dispatch_br_target == ref_target(dispatch_pc, mem_word))
                    else report_mismatch($sformatf("target %h at pc %h, expected %h",
                        dispatch_br_target, dispatch_pc, ref_target(dispatch_pc, mem_word)));
            end
            if (dispatch_valid && dispatch_ready) begin
                assert (dispatch_pc == expect_pc)
                    else report_mismatch($sformatf("dispatched pc %h, expected %h",
                        dispatch_pc, expect_pc));
                expect_pc = ref_target(dispatch_pc, mem_word);
                deq_count++;
                if (dispatch_pc == watch_pc) begin
                    watch_hits++;
                end
                if (backend_stall) begin
                    stall_deqs++;
                    assert (stall_deqs <= FIFO_DEPTH)
                        else report_mismatch("more dispatches under stall than queue entries");
                end
            end
            if (!backend_stall) begin
                stall_deqs = 0;
            end
            hold_pending = dispatch_valid && !dispatch_ready && !recovery_valid;
            held_fields = dispatch_fields;
            // queue is cleared, stream restarts here
            if (recovery_valid) begin
                expect_pc = recovery_pc;
            end
        end
    end

    // mostly ready, forced low for back-pressure
    always @(posedge clk) begin
        #5;
        ready_rand = $random(seed);
        dispatch_ready = !ready_low && (ready_rand[1:0] != 2'b00);
    end

    task automatic wait_for_pc(input addr_t pc, input int limit);
        int start;
        int n;
        watch_pc = pc;
        start = watch_hits;
        n = 0;
        while (!timed_out && watch_hits == start) begin
            @(posedge clk);
            #5;
            n++;
            if (n > limit) begin
                $display("timeout: pc %h was never dispatched", pc);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_for_deqs(input int count, input int limit);
        int target;
        int n;
        target = deq_count + count;
        n = 0;
        while (!timed_out && deq_count < target) begin
            @(posedge clk);
            #5;
            n++;
            if (n > limit) begin
                $display("timeout: only %0d of %0d entries dispatched", count - target + deq_count,
                    count);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_for_request(input int limit);
        int n;
        n = 0;
        while (!timed_out && !mem_req_valid) begin
            @(posedge clk);
            #5;
            n++;
            if (n > limit) begin
                $display("timeout: no memory request was made");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic redirect(input addr_t pc);
        recovery_pc = pc;
        recovery_valid = 1'b1;
        @(posedge clk);
        #5;
        recovery_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (timed_out) begin
            $display("test %s: stopped by a timeout", name);
            tests_failed++;
        end else if (errors == test_base) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d failed checks", name, errors - test_base);
            tests_failed++;
        end
        test_base = errors;
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        backend_stall = 1'b0;
        recovery_valid = 1'b0;
        recovery_pc = '0;
        dispatch_ready = 1'b0;
        seed = 67490;
        ready_low = 1'b0;
        expect_pc = RESET_PC;
        watch_pc = '0;
        watch_hits = 0;
        deq_count = 0;
        stall_deqs = 0;
        hold_pending = 1'b0;
        held_fields = '0;
        errors = 0;
        test_base = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        arst_n = 1'b1;
        // first fetch misses on a cold cache
        wait_for_pc(RESET_PC, 100);
        end_test("reset and first fetch");
        wait_for_pc(32'h40, 400);
        wait_for_deqs(12, 300);
        end_test("sequential fetch and backward branch loop");
        ready_low = 1'b1;
        hold_cycles(30);
        ready_low = 1'b0;
        wait_for_deqs(10, 200);
        ready_low = 1'b1;
        hold_cycles(25);
        ready_low = 1'b0;
        wait_for_deqs(16, 200);
        end_test("dispatch back-pressure");
        // out of the loop, through 0x80 and the jal
        redirect(32'h44);
        wait_for_pc(32'h80, 600);
        wait_for_pc(32'h100, 600);
        wait_for_pc(32'h20, 300);
        wait_for_pc(32'h40, 300);
        end_test("redirect, forward branch and jal");
        // set 0 holds 0x100 now, so pc 0 refills
        redirect(32'h0);
        wait_for_request(50);
        redirect(32'h88);
        wait_for_pc(32'h88, 100);
        wait_for_pc(32'h20, 600);
        end_test("redirect during refill");
        backend_stall = 1'b1;
        hold_cycles(30);
        backend_stall = 1'b0;
        wait_for_deqs(10, 200);
        end_test("backend stall");
        $display("tests passed %0d, tests failed %0d, failed checks %0d",
            tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
src/fetch_pkg.sv
src/fetch_entry_if.sv
src/fetch_pc_icache.sv
src/predecode_npc.sv
src/instr_fifo.sv
src/ifu.sv
sim/tb_mem_model.sv
sim/tb_ifu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ifu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ifu -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ifu)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
